// File: project.f
design/mem_bus_pkg.sv
design/bus_arbiter.sv
design/simplebus_axi_master.sv
design/axi_addr_router.sv
design/clint_timer.sv
design/mem_subsystem_top.sv
dv/bus_checker.sv
dv/tb_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f project.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

// File: dv/tb_top.sv
`timescale 1ns/10ps

module tb_top;

    localparam int max_cycles = 40 * 200;
    localparam logic [31:0] ext_base = 32'h8000_0000;

    logic                 clock;
    logic                 reset;
    mem_bus_pkg::sb_req_t fetch_req;
    mem_bus_pkg::sb_rsp_t fetch_rsp;
    mem_bus_pkg::sb_req_t lsu_req;
    mem_bus_pkg::sb_rsp_t lsu_rsp;
    mem_bus_pkg::axi_ar_t io_master_ar;
    logic                 io_master_arready;
    mem_bus_pkg::axi_aw_t io_master_aw;
    logic                 io_master_awready;
    mem_bus_pkg::axi_w_t  io_master_w;
    logic                 io_master_wready;
    mem_bus_pkg::axi_r_t  io_master_r;
    logic                 io_master_rready;
    mem_bus_pkg::axi_b_t  io_master_b;
    logic                 io_master_bready;

    integer      seed;
    int          cycles;
    logic [31:0] ext_mem [256];

    mem_subsystem_top i_dut (.*);

    bus_checker i_check (
        .clock            (clock),
        .reset            (reset),
        .fetch_req        (fetch_req),
        .fetch_rsp        (fetch_rsp),
        .lsu_req          (lsu_req),
        .lsu_rsp          (lsu_rsp),
        .io_master_ar     (io_master_ar),
        .io_master_aw     (io_master_aw),
        .io_master_w      (io_master_w),
        .io_master_rready (io_master_rready),
        .io_master_bready (io_master_bready)
    );

    function automatic logic [31:0] fill_word(input int i);
        logic [7:0] b;
        b = i[7:0];
        return {~b, b, b ^ 8'h5a, 8'hc3};
    endfunction

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // run limit.
    always @(posedge clock) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, a transaction never completed", cycles);
            $display("errors: %0d", i_check.error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ************************************************************************
    // requesters, called on a falling edge
    // ************************************************************************
    task automatic lsu_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] mask);
        lsu_req.valid = 1'b1;
        lsu_req.write = write;
        lsu_req.addr  = addr;
        lsu_req.wdata = data;
        lsu_req.mask  = mask;
        lsu_req.size  = 3'd2;
        do @(negedge clock); while (!lsu_rsp.complete);
        @(negedge clock);   // valid drops in the cycle after complete.
        lsu_req = '0;
    endtask

    task automatic fetch_read(input logic [31:0] addr);
        fetch_req.valid = 1'b1;
        fetch_req.addr  = addr;
        fetch_req.mask  = 4'hf;
        fetch_req.size  = 3'd2;
        do @(negedge clock); while (!fetch_rsp.complete);
        @(negedge clock);
        fetch_req = '0;
    endtask

    // ************************************************************************
    // external slave, 256 words
    // ************************************************************************
    initial begin : ext_slave
        logic [31:0] rnd;
        logic [7:0]  idx;
        forever begin
            @(posedge clock);
            if (!reset && io_master_ar.valid) begin
                idx = io_master_ar.addr[9:2];
                rnd = $random(seed);
                repeat (rnd[1:0]) @(posedge clock);
                @(negedge clock) io_master_arready = 1'b1;
                @(negedge clock) io_master_arready = 1'b0;
                io_master_r.valid = 1'b1;
                io_master_r.data  = ext_mem[idx];
                io_master_r.resp  = mem_bus_pkg::resp_okay;
                do @(posedge clock); while (!io_master_rready);
                @(negedge clock) io_master_r = '0;
            end else if (!reset && io_master_aw.valid && io_master_w.valid) begin
                idx = io_master_aw.addr[9:2];
                rnd = $random(seed);
                repeat (rnd[1:0]) @(posedge clock);
                @(negedge clock);
                io_master_awready = 1'b1;
                io_master_wready  = 1'b1;
                @(negedge clock);
                io_master_awready = 1'b0;
                io_master_wready  = 1'b0;
                for (int k = 0; k < 4; k++) begin
                    if (io_master_w.strb[k]) ext_mem[idx][8*k +: 8] = io_master_w.data[8*k +: 8];
                end
                io_master_b.valid = 1'b1;
                io_master_b.resp  = mem_bus_pkg::resp_okay;
                do @(posedge clock); while (!io_master_bready);
                @(negedge clock) io_master_b = '0;
            end
        end
    end

    // ************************************************************************
    // stimulus
    // ************************************************************************
    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] data;
        seed              = 53571;
        cycles            = 0;
        reset             = 1'b1;
        fetch_req         = '0;
        lsu_req           = '0;
        io_master_arready = 1'b0;
        io_master_awready = 1'b0;
        io_master_wready  = 1'b0;
        io_master_r       = '0;
        io_master_b       = '0;
        for (int i = 0; i < 256; i++) ext_mem[i] = fill_word(i);

        repeat (2) @(posedge clock);
        @(negedge clock) reset = 1'b0;
        repeat (3) @(negedge clock);

        for (int n = 0; n < 150; n++) begin
            rnd  = $random(seed);
            addr = ext_base | {22'd0, rnd[9:2], 2'b00};
            data = $random(seed);
            case (rnd[31:30])
                2'd0: lsu_access(1'b0, addr, '0, 4'hf);
                2'd1: lsu_access(1'b1, addr, data, rnd[13:10]);
                2'd2: fetch_read(addr);
                default: begin
                    // same-cycle requests, load/store goes first.
                    fork
                        lsu_access(rnd[14], addr, data, rnd[13:10]);
                        fetch_read(ext_base | {22'd0, data[7:0], 2'b00});
                    join
                end
            endcase
            repeat (rnd[17:16]) @(negedge clock);
        end

        // CLINT
        repeat (2) @(negedge clock);
        lsu_access(1'b0, mem_bus_pkg::clint_base, '0, 4'hf);
        @(negedge clock);
        lsu_access(1'b0, mem_bus_pkg::clint_base + 32'h4, '0, 4'hf);
        @(negedge clock);
        lsu_access(1'b0, mem_bus_pkg::clint_base + 32'h8, '0, 4'hf);
        @(negedge clock);
        lsu_access(1'b1, mem_bus_pkg::clint_base, 32'hdead_beef, 4'hf);
        @(negedge clock);
        lsu_access(1'b1, mem_bus_pkg::clint_base + 32'h4, 32'h1234_5678, 4'h3);
        @(negedge clock);
        lsu_access(1'b0, mem_bus_pkg::clint_base, '0, 4'hf);

        repeat (2) @(negedge clock);
        $display("errors: %0d", i_check.error_count);
        if (i_check.error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dv/bus_checker.sv
`timescale 1ns/10ps

module bus_checker (
    input logic                 clock,
    input logic                 reset,
    input mem_bus_pkg::sb_req_t fetch_req,
    input mem_bus_pkg::sb_rsp_t fetch_rsp,
    input mem_bus_pkg::sb_req_t lsu_req,
    input mem_bus_pkg::sb_rsp_t lsu_rsp,
    input mem_bus_pkg::axi_ar_t io_master_ar,
    input mem_bus_pkg::axi_aw_t io_master_aw,
    input mem_bus_pkg::axi_w_t  io_master_w,
    input logic                 io_master_rready,
    input logic                 io_master_bready
);

    int          error_count;
    logic [31:0] cycle_count;   // equals mtime, both start at reset release.
    logic [31:0] shadow [256];
    logic        fetch_pend;
    logic        lsu_pend;
    logic        lsu_idle;
    logic [31:0] fetch_start;
    logic [31:0] lsu_start;

    function automatic logic [31:0] initial_word(input int i);
        logic [7:0] b;
        b = i[7:0];
        return {~b, b, b ^ 8'h5a, 8'hc3};
    endfunction

    function automatic logic is_clint(input logic [31:0] addr);
        return (addr >= mem_bus_pkg::clint_base) &&
               (addr < mem_bus_pkg::clint_base + mem_bus_pkg::clint_size);
    endfunction

    // ************************************************************************
    // reference model
    // ************************************************************************
    function automatic mem_bus_pkg::sb_rsp_t expected_rsp(input logic write,
                                                          input logic [31:0] addr);
        mem_bus_pkg::sb_rsp_t e;
        e          = '0;
        e.complete = 1'b1;
        if (is_clint(addr)) begin
            e.resp = write ? mem_bus_pkg::resp_slverr : mem_bus_pkg::resp_okay;
        end else begin
            e.resp = mem_bus_pkg::resp_okay;
            if (!write) e.rdata = shadow[addr[9:2]];
        end
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] actual);
        if (actual !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, actual);
            error_count++;
        end
    endtask

    task automatic check_done(input string name, input mem_bus_pkg::sb_req_t req,
                              input mem_bus_pkg::sb_rsp_t rsp, input logic [31:0] start,
                              input logic idle);
        mem_bus_pkg::sb_rsp_t exp;
        logic [31:0]          off;
        exp = expected_rsp(req.write, req.addr);
        off = req.addr - mem_bus_pkg::clint_base;
        if (rsp.resp !== exp.resp) begin
            $display("CHECK FAILED %s.resp expected %h actual %h", name, exp.resp, rsp.resp);
            error_count++;
        end
        if (!req.write) begin
            if (is_clint(req.addr) && off == 32'h0) begin
                if (rsp.rdata < start || rsp.rdata > cycle_count) begin
                    $display("CHECK FAILED %s.rdata expected %h..%h actual %h",
                             name, start, cycle_count, rsp.rdata);
                    error_count++;
                end
            end else if (rsp.rdata !== exp.rdata) begin
                $display("CHECK FAILED %s.rdata expected %h actual %h",
                         name, exp.rdata, rsp.rdata);
                error_count++;
            end
            if (is_clint(req.addr) && idle && (cycle_count - start) != 32'd3) begin
                $display("CLINT read at %h took %0d cycles instead of 3",
                         req.addr, cycle_count - start);
                error_count++;
            end
        end else if (!is_clint(req.addr)) begin
            for (int k = 0; k < 4; k++) begin
                if (req.mask[k]) shadow[req.addr[9:2]][8*k +: 8] = req.wdata[8*k +: 8];
            end
        end
    endtask

    initial begin
        error_count = 0;
        cycle_count = '0;
        fetch_pend  = 1'b0;
        lsu_pend    = 1'b0;
        lsu_idle    = 1'b0;
        fetch_start = '0;
        lsu_start   = '0;
        for (int i = 0; i < 256; i++) shadow[i] = initial_word(i);
    end

    // ************************************************************************
    // compare on every edge
    // ************************************************************************
    always @(posedge clock) begin
        mem_bus_pkg::sb_req_t f;
        mem_bus_pkg::sb_req_t cur;
        f       = fetch_req;
        f.write = 1'b0;   // fetch only reads.
        cur     = (lsu_pend && (!fetch_pend || lsu_start <= fetch_start)) ? lsu_req : f;
        if (reset) begin
            cycle_count = '0;
        end else begin
            if (cycle_count == 32'd0 &&
                (fetch_rsp.complete || lsu_rsp.complete || io_master_ar.valid ||
                 io_master_aw.valid || io_master_w.valid || io_master_rready ||
                 io_master_bready)) begin
                $display("outputs were not idle right after reset");
                error_count++;
            end
            if (io_master_aw.valid && is_clint(io_master_aw.addr)) begin
                $display("CLINT write at %h reached the external port", io_master_aw.addr);
                error_count++;
            end
            // external beats carry the request in flight.
            if (io_master_ar.valid) begin
                compare_field("io_master_ar.addr", cur.addr, io_master_ar.addr);
                compare_field("io_master_ar.size", {29'd0, cur.size},
                              {29'd0, io_master_ar.size});
            end
            if (io_master_aw.valid) begin
                compare_field("io_master_aw.addr", cur.addr, io_master_aw.addr);
                compare_field("io_master_aw.size", {29'd0, cur.size},
                              {29'd0, io_master_aw.size});
            end
            if (io_master_w.valid) begin
                compare_field("io_master_w.data", cur.wdata, io_master_w.data);
                compare_field("io_master_w.strb", {28'd0, cur.mask},
                              {28'd0, io_master_w.strb});
            end
            // load/store
            if (lsu_rsp.complete) begin
                if (!lsu_pend) begin
                    $display("load/store got a complete with no request pending");
                    error_count++;
                end else begin
                    check_done("lsu_rsp", lsu_req, lsu_rsp, lsu_start, lsu_idle);
                end
                lsu_pend = 1'b0;
            end else if (lsu_req.valid && !lsu_pend) begin
                lsu_pend  = 1'b1;
                lsu_start = cycle_count;
                lsu_idle  = !fetch_pend;
            end
            // fetch
            if (fetch_rsp.complete) begin
                if (!fetch_pend) begin
                    $display("fetch got a complete with no request pending");
                    error_count++;
                end else begin
                    if (lsu_pend && lsu_start <= fetch_start) begin
                        $display("fetch completed before an older or equal load/store");
                        error_count++;
                    end
                    check_done("fetch_rsp", f, fetch_rsp, fetch_start, 1'b0);
                end
                fetch_pend = 1'b0;
            end else if (fetch_req.valid && !fetch_pend) begin
                fetch_pend  = 1'b1;
                fetch_start = cycle_count;
            end
            cycle_count = cycle_count + 32'd1;
        end
    end

endmodule

// File: design/mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top (
    input  logic                 clock,
    input  logic                 reset,
    input  mem_bus_pkg::sb_req_t fetch_req,
    output mem_bus_pkg::sb_rsp_t fetch_rsp,
    input  mem_bus_pkg::sb_req_t lsu_req,
    output mem_bus_pkg::sb_rsp_t lsu_rsp,
    output mem_bus_pkg::axi_ar_t io_master_ar,
    input  logic                 io_master_arready,
    output mem_bus_pkg::axi_aw_t io_master_aw,
    input  logic                 io_master_awready,
    output mem_bus_pkg::axi_w_t  io_master_w,
    input  logic                 io_master_wready,
    input  mem_bus_pkg::axi_r_t  io_master_r,
    output logic                 io_master_rready,
    input  mem_bus_pkg::axi_b_t  io_master_b,
    output logic                 io_master_bready
);

    mem_bus_pkg::sb_req_t bus_req;
    mem_bus_pkg::sb_rsp_t bus_rsp;
    mem_bus_pkg::axi_ar_t ar;
    mem_bus_pkg::axi_aw_t aw;
    mem_bus_pkg::axi_w_t  w;
    mem_bus_pkg::axi_r_t  r;
    mem_bus_pkg::axi_b_t  b;
    logic                 arready;
    logic                 awready;
    logic                 wready;
    logic                 rready;
    logic                 bready;

    // CLINT side.
    mem_bus_pkg::axi_ar_t clint_ar;
    mem_bus_pkg::axi_r_t  clint_r;
    logic                 clint_arready;
    logic                 clint_rready;

    bus_arbiter u_bus_arbiter (
        .clock     (clock),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .lsu_req   (lsu_req),
        .lsu_rsp   (lsu_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

    simplebus_axi_master u_simplebus_axi_master (
        .clock   (clock),
        .reset   (reset),
        .req     (bus_req),
        .rsp     (bus_rsp),
        .ar      (ar),
        .arready (arready),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .r       (r),
        .rready  (rready),
        .b       (b),
        .bready  (bready)
    );

    axi_addr_router u_axi_addr_router (
        .clock         (clock),
        .reset         (reset),
        .ar            (ar),
        .arready       (arready),
        .aw            (aw),
        .awready       (awready),
        .w             (w),
        .wready        (wready),
        .r             (r),
        .rready        (rready),
        .b             (b),
        .bready        (bready),
        .clint_ar      (clint_ar),
        .clint_arready (clint_arready),
        .clint_r       (clint_r),
        .clint_rready  (clint_rready),
        .ext_ar        (io_master_ar),
        .ext_arready   (io_master_arready),
        .ext_aw        (io_master_aw),
        .ext_awready   (io_master_awready),
        .ext_w         (io_master_w),
        .ext_wready    (io_master_wready),
        .ext_r         (io_master_r),
        .ext_rready    (io_master_rready),
        .ext_b         (io_master_b),
        .ext_bready    (io_master_bready)
    );

    clint_timer u_clint_timer (
        .clock   (clock),
        .reset   (reset),
        .ar      (clint_ar),
        .arready (clint_arready),
        .r       (clint_r),
        .rready  (clint_rready)
    );

endmodule

// File: design/clint_timer.sv
`timescale 1ns/10ps

module clint_timer (
    input  logic                 clock,
    input  logic                 reset,
    input  mem_bus_pkg::axi_ar_t ar,
    output logic                 arready,
    output mem_bus_pkg::axi_r_t  r,
    input  logic                 rready
);

    localparam int dw = mem_bus_pkg::data_width;

    logic [2*dw-1:0]                    mtime;
    logic [mem_bus_pkg::addr_width-1:0] offset;
    logic [dw-1:0]                      rdata_q;
    logic                               rvalid_q;

    assign offset  = ar.addr - mem_bus_pkg::clint_base;
    assign arready = ~rvalid_q;   // idle means no read pending.

    assign r.valid = rvalid_q;
    assign r.data  = rdata_q;
    assign r.resp  = mem_bus_pkg::resp_okay;

    always_ff @(posedge clock) begin
        if (reset) begin
            mtime    <= '0;
            rvalid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar.valid && arready) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // sampled at the AR handshake.
    always_ff @(posedge clock) begin
        if (ar.valid && arready) begin
            case (offset)
                32'h0:   rdata_q <= mtime[dw-1:0];
                32'h4:   rdata_q <= mtime[2*dw-1:dw];
                default: rdata_q <= '0;
            endcase
        end
    end

endmodule

// File: design/axi_addr_router.sv
`timescale 1ns/10ps

module axi_addr_router (
    input  logic                 clock,
    input  logic                 reset,
    input  mem_bus_pkg::axi_ar_t ar,
    output logic                 arready,
    input  mem_bus_pkg::axi_aw_t aw,
    output logic                 awready,
    input  mem_bus_pkg::axi_w_t  w,
    output logic                 wready,
    output mem_bus_pkg::axi_r_t  r,
    input  logic                 rready,
    output mem_bus_pkg::axi_b_t  b,
    input  logic                 bready,
    output mem_bus_pkg::axi_ar_t clint_ar,
    input  logic                 clint_arready,
    input  mem_bus_pkg::axi_r_t  clint_r,
    output logic                 clint_rready,
    output mem_bus_pkg::axi_ar_t ext_ar,
    input  logic                 ext_arready,
    output mem_bus_pkg::axi_aw_t ext_aw,
    input  logic                 ext_awready,
    output mem_bus_pkg::axi_w_t  ext_w,
    input  logic                 ext_wready,
    input  mem_bus_pkg::axi_r_t  ext_r,
    output logic                 ext_rready,
    input  mem_bus_pkg::axi_b_t  ext_b,
    output logic                 ext_bready
);

    logic ar_is_clint;
    logic rd_busy;
    logic rd_clint_q;
    logic aw_is_clint;
    logic wr_sel_clint;
    logic aw_acc_q;
    logic w_acc_q;
    logic wr_clint_q;
    logic clint_b_q;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    function automatic logic in_clint(input logic [mem_bus_pkg::addr_width-1:0] addr);
        return (addr >= mem_bus_pkg::clint_base) &&
               (addr < mem_bus_pkg::clint_base + mem_bus_pkg::clint_size);
    endfunction

    // ************************************************************************
    // read path
    // ************************************************************************
    assign ar_is_clint = in_clint(ar.addr);

    always_comb begin
        clint_ar       = ar;
        clint_ar.valid = ar.valid & ar_is_clint & ~rd_busy;
        ext_ar         = ar;
        ext_ar.valid   = ar.valid & ~ar_is_clint & ~rd_busy;
        arready        = ~rd_busy & (ar_is_clint ? clint_arready : ext_arready);
        r              = rd_clint_q ? clint_r : ext_r;
        r.valid        = rd_busy & (rd_clint_q ? clint_r.valid : ext_r.valid);
    end

    assign clint_rready = rready & rd_busy & rd_clint_q;
    assign ext_rready   = rready & rd_busy & ~rd_clint_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_busy    <= 1'b0;
            rd_clint_q <= 1'b0;
        end else if (ar.valid && arready) begin
            rd_busy    <= 1'b1;
            rd_clint_q <= ar_is_clint;   // target held for the R beat.
        end else if (r.valid && rready) begin
            rd_busy <= 1'b0;
        end
    end

    // ************************************************************************
    // write path, CLINT writes end here with an error
    // ************************************************************************
    assign aw_is_clint  = in_clint(aw.addr);
    assign wr_sel_clint = aw_acc_q ? wr_clint_q : aw_is_clint;
    assign aw_hs        = aw.valid & awready;
    assign w_hs         = w.valid & wready;
    assign b_hs         = b.valid & bready;

    always_comb begin
        ext_aw       = aw;
        ext_aw.valid = aw.valid & ~aw_acc_q & ~aw_is_clint;
        awready      = ~aw_acc_q & (aw_is_clint | ext_awready);
        ext_w        = w;
        ext_w.valid  = w.valid & ~w_acc_q & ~wr_sel_clint;
        wready       = ~w_acc_q & (wr_sel_clint | ext_wready);
        b            = ext_b;
        if (wr_sel_clint) begin
            b.valid = clint_b_q;
            b.resp  = mem_bus_pkg::resp_slverr;
        end
    end

    assign ext_bready = bready & ~wr_sel_clint;

    always_ff @(posedge clock) begin
        if (reset || b_hs) begin
            aw_acc_q   <= 1'b0;
            w_acc_q    <= 1'b0;
            wr_clint_q <= 1'b0;
            clint_b_q  <= 1'b0;
        end else begin
            aw_acc_q <= aw_acc_q | aw_hs;
            w_acc_q  <= w_acc_q | w_hs;
            if (aw_hs) wr_clint_q <= aw_is_clint;
            // local B rises the cycle after both beats are in.
            if ((aw_acc_q || aw_hs) && (w_acc_q || w_hs) && wr_sel_clint) clint_b_q <= 1'b1;
        end
    end

endmodule

// File: design/simplebus_axi_master.sv
`timescale 1ns/10ps

module simplebus_axi_master (
    input  logic                 clock,
    input  logic                 reset,
    input  mem_bus_pkg::sb_req_t req,
    output mem_bus_pkg::sb_rsp_t rsp,
    output mem_bus_pkg::axi_ar_t ar,
    input  logic                 arready,
    output mem_bus_pkg::axi_aw_t aw,
    input  logic                 awready,
    output mem_bus_pkg::axi_w_t  w,
    input  logic                 wready,
    input  mem_bus_pkg::axi_r_t  r,
    output logic                 rready,
    input  mem_bus_pkg::axi_b_t  b,
    output logic                 bready
);

    typedef enum logic [1:0] {
        st_idle,
        st_address,
        st_data,
        st_done
    } state_t;

    state_t                             state;
    mem_bus_pkg::sb_req_t               req_q;
    logic                               aw_done;
    logic                               w_done;
    logic                               aw_hs;
    logic                               w_hs;
    logic [mem_bus_pkg::data_width-1:0] rdata_q;
    logic [1:0]                         resp_q;

    assign aw_hs = aw.valid & awready;
    assign w_hs  = w.valid & wready;

    // ************************************************************************
    // channel outputs
    // ************************************************************************
    always_comb begin
        ar.valid = (state == st_address) & ~req_q.write;
        ar.addr  = req_q.addr;
        ar.size  = req_q.size;
        aw.valid = (state == st_address) & req_q.write & ~aw_done;
        aw.addr  = req_q.addr;
        aw.size  = req_q.size;
        w.valid  = (state == st_address) & req_q.write & ~w_done;
        w.data   = req_q.wdata;
        w.strb   = req_q.mask;
    end

    assign rready = (state == st_data) & ~req_q.write;
    assign bready = (state == st_data) & req_q.write;

    assign rsp.complete = (state == st_done);
    assign rsp.rdata    = rdata_q;
    assign rsp.resp     = resp_q;

    // ************************************************************************
    // FSM
    // ************************************************************************
    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (req.valid) state <= st_address;
                end
                st_address: begin
                    if (req_q.write) begin
                        aw_done <= aw_done | aw_hs;
                        w_done  <= w_done | w_hs;
                        // both beats may land in different cycles.
                        if ((aw_done || aw_hs) && (w_done || w_hs)) state <= st_data;
                    end else if (arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (req_q.write ? b.valid : r.valid) state <= st_done;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle && req.valid) req_q <= req;
        if (state == st_data && !req_q.write && r.valid) begin
            rdata_q <= r.data;
            resp_q  <= r.resp;
        end
        if (state == st_data && req_q.write && b.valid) begin
            rdata_q <= '0;
            resp_q  <= b.resp;
        end
    end

endmodule

// File: design/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
    input  logic                 clock,
    input  logic                 reset,
    input  mem_bus_pkg::sb_req_t fetch_req,
    output mem_bus_pkg::sb_rsp_t fetch_rsp,
    input  mem_bus_pkg::sb_req_t lsu_req,
    output mem_bus_pkg::sb_rsp_t lsu_rsp,
    output mem_bus_pkg::sb_req_t bus_req,
    input  mem_bus_pkg::sb_rsp_t bus_rsp
);

    logic                 busy;
    logic                 grant_lsu_q;
    logic                 grant_lsu;
    mem_bus_pkg::sb_req_t fetch_rd;

    // fetch never writes.
    always_comb begin
        fetch_rd       = fetch_req;
        fetch_rd.write = 1'b0;
    end

    // load/store wins a tie while idle.
    assign grant_lsu = busy ? grant_lsu_q : lsu_req.valid;

    always_comb begin
        if (grant_lsu) begin
            bus_req = lsu_req;
        end else begin
            bus_req = fetch_rd;
        end
    end

    // response goes only to the side holding the grant.
    always_comb begin
        fetch_rsp          = bus_rsp;
        lsu_rsp            = bus_rsp;
        fetch_rsp.complete = bus_rsp.complete & busy & ~grant_lsu_q;
        lsu_rsp.complete   = bus_rsp.complete & busy & grant_lsu_q;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy        <= 1'b0;
            grant_lsu_q <= 1'b0;
        end else if (!busy) begin
            if (lsu_req.valid || fetch_req.valid) begin
                busy        <= 1'b1;
                grant_lsu_q <= lsu_req.valid;
            end
        end else if (bus_rsp.complete) begin
            busy <= 1'b0;   // released at the complete pulse.
        end
    end

endmodule

// File: design/mem_bus_pkg.sv
package mem_bus_pkg;

    // ************************************************************************
    // widths and memory map
    // ************************************************************************
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    localparam logic [addr_width-1:0] clint_base = 32'h0200_0000;
    localparam logic [addr_width-1:0] clint_size = 32'h0001_0000;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // ************************************************************************
    // simple bus
    // ************************************************************************
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic [strb_width-1:0] mask;
        logic [2:0]            size;
    } sb_req_t;

    typedef struct packed {
        logic                  complete;   // one-cycle pulse.
        logic [data_width-1:0] rdata;
        logic [1:0]            resp;
    } sb_rsp_t;

    // ************************************************************************
    // AXI4-lite channels, ready runs separately
    // ************************************************************************
    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
        logic [2:0]            size;
    } axi_ar_t;

    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
        logic [2:0]            size;
    } axi_aw_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] data;
        logic [1:0]            resp;
    } axi_r_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

endpackage
